//--- periph_defines.svh
// Address map, register offsets and sizing of the peripheral subsystem
// Error-slave read pattern
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// --------------------------------------------------
// Regions, taken from address bits 15:12
// --------------------------------------------------
`define PERIPH_REGION_PLIC  4'h0
`define PERIPH_REGION_TIMER 4'h1

// Sizing
`define PERIPH_NUM_SRC   8
`define PERIPH_PRIO_W    3
`define PERIPH_NUM_TIMER 2

// Returned for unmapped regions
`define PERIPH_ERR_DATA  32'hDEAD_BEEF

// --------------------------------------------------
// PLIC offsets
// --------------------------------------------------
`define PLIC_PRIO_BASE 12'h000
`define PLIC_PENDING   12'h080
`define PLIC_ENABLE    12'h100
`define PLIC_THRESHOLD 12'h200
`define PLIC_CLAIM     12'h204

// Timer offsets, timer n sits at 0x10 * n
`define TIMER_COUNT   4'h0
`define TIMER_CTRL    4'h4
`define TIMER_COMPARE 4'h8
`define TIMER_STATUS  4'hC

`endif

//--- periph_bus_pkg.sv
// APB address, data and register offset types
// Region enum used by the decoder and the response mux

package periph_bus_pkg;

    // Bus address and data words
    typedef logic [31:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Offset inside one 4 KiB region
    typedef logic [11:0] reg_offset_t;

    // Decoded slave region
    typedef enum logic [1:0] {
        REGION_PLIC,
        REGION_TIMER,
        REGION_NONE
    } periph_region_e;

endpackage

//--- periph_irq_pkg.sv
// Interrupt source vector, priority and source id types

`include "periph_defines.svh"

package periph_irq_pkg;

    // One bit per source, bit i is source id i
    typedef logic [`PERIPH_NUM_SRC-1:0] irq_src_t;

    typedef logic [`PERIPH_PRIO_W-1:0] irq_prio_t;

    // Id 0 means no source
    typedef logic [$clog2(`PERIPH_NUM_SRC)-1:0] irq_id_t;

endpackage

//--- periph_apb_decoder.sv
// APB input decoder
// Region decode, register offset and per-slave access strobes

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_apb_decoder (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  periph_bus_pkg::apb_addr_t      paddr_i,
    output periph_bus_pkg::periph_region_e region_o,
    output periph_bus_pkg::reg_offset_t    offset_o,
    output logic                           plic_we_o,
    output logic                           plic_re_o,
    output logic                           timer_we_o,
    output logic                           timer_re_o
);

    logic access;

    always_comb begin
        case (paddr_i[15:12])
            `PERIPH_REGION_PLIC:  region_o = periph_bus_pkg::REGION_PLIC;
            `PERIPH_REGION_TIMER: region_o = periph_bus_pkg::REGION_TIMER;
            default:              region_o = periph_bus_pkg::REGION_NONE;
        endcase
    end

    assign offset_o = paddr_i[11:0];

    // Access phase of a transfer
    assign access = psel_i & penable_i;

    assign plic_we_o  = access & pwrite_i & (region_o == periph_bus_pkg::REGION_PLIC);
    assign plic_re_o  = access & ~pwrite_i & (region_o == periph_bus_pkg::REGION_PLIC);
    assign timer_we_o = access & pwrite_i & (region_o == periph_bus_pkg::REGION_TIMER);
    assign timer_re_o = access & ~pwrite_i & (region_o == periph_bus_pkg::REGION_TIMER);

    // Only one slave is ever addressed
    strobe_onehot_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({plic_we_o, plic_re_o, timer_we_o, timer_re_o})
    );

endmodule

//--- periph_timer.sv
// Two compare timers behind the APB register strobes
// Count, control, compare and status registers, level interrupt per timer

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_timer (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          we_i,
    input  logic                          re_i,
    input  periph_bus_pkg::reg_offset_t   offset_i,
    input  periph_bus_pkg::apb_data_t     wdata_i,
    output periph_bus_pkg::apb_data_t     rdata_o,
    output logic                          offset_err_o,
    output logic [`PERIPH_NUM_TIMER-1:0]  irq_o
);

    periph_bus_pkg::apb_data_t count_q   [`PERIPH_NUM_TIMER];
    periph_bus_pkg::apb_data_t compare_q [`PERIPH_NUM_TIMER];
    logic [`PERIPH_NUM_TIMER-1:0] enable_q;
    logic [`PERIPH_NUM_TIMER-1:0] pending_q;

    logic [`PERIPH_NUM_TIMER-1:0] wr_hit;
    logic [`PERIPH_NUM_TIMER-1:0] match;
    logic [$clog2(`PERIPH_NUM_TIMER)-1:0] tidx;
    logic sel_valid;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------
    assign tidx      = offset_i[4 +: $clog2(`PERIPH_NUM_TIMER)];
    assign sel_valid = (offset_i[11:4] < 8'(`PERIPH_NUM_TIMER)) && (offset_i[1:0] == 2'b00);

    always_comb begin
        for (int i = 0; i < `PERIPH_NUM_TIMER; i++) begin
            wr_hit[i] = we_i && sel_valid && (offset_i[11:4] == 8'(i));
            match[i]  = enable_q[i] && (count_q[i] == compare_q[i]);
        end
    end

    // --------------------------------------------------
    // Counters and registers
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PERIPH_NUM_TIMER; i++) begin
                count_q[i]   <= '0;
                compare_q[i] <= '0;
            end
            enable_q  <= '0;
            pending_q <= '0;
        end else begin
            for (int i = 0; i < `PERIPH_NUM_TIMER; i++) begin
                if (match[i]) begin
                    count_q[i] <= '0;
                end else if (enable_q[i]) begin
                    count_q[i] <= count_q[i] + 32'd1;
                end
                // Bus writes override the running count
                if (wr_hit[i] && offset_i[3:0] == `TIMER_COUNT) begin
                    count_q[i] <= wdata_i;
                end
                if (wr_hit[i] && offset_i[3:0] == `TIMER_CTRL) begin
                    enable_q[i] <= wdata_i[0];
                end
                if (wr_hit[i] && offset_i[3:0] == `TIMER_COMPARE) begin
                    compare_q[i] <= wdata_i;
                end
                if (wr_hit[i] && offset_i[3:0] == `TIMER_STATUS && wdata_i[0]) begin
                    pending_q[i] <= 1'b0;
                end
                // A new match beats a clear in the same cycle
                if (match[i]) begin
                    pending_q[i] <= 1'b1;
                end
            end
        end
    end

    // Read path
    always_comb begin
        rdata_o = '0;
        if (sel_valid) begin
            case (offset_i[3:0])
                `TIMER_COUNT:   rdata_o = count_q[tidx];
                `TIMER_CTRL:    rdata_o = {31'b0, enable_q[tidx]};
                `TIMER_COMPARE: rdata_o = compare_q[tidx];
                default:        rdata_o = {31'b0, pending_q[tidx]};
            endcase
        end
    end

    assign offset_err_o = (we_i | re_i) & ~sel_valid;
    assign irq_o        = pending_q;

    for (genvar g = 0; g < `PERIPH_NUM_TIMER; g++) begin : gen_chk
        // Pending only comes from a match of an enabled timer
        pend_needs_en_a: assert property (
            @(posedge clk_i) disable iff (!rst_n_i)
            $rose(pending_q[g]) |-> $past(enable_q[g])
        );
    end

endmodule

//--- periph_plic.sv
// Level-triggered interrupt controller, single target
// Gateways, priority/enable/threshold registers, best-source select,
// claim/complete and the target interrupt

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_plic (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        we_i,
    input  logic                        re_i,
    input  periph_bus_pkg::reg_offset_t offset_i,
    input  periph_bus_pkg::apb_data_t   wdata_i,
    input  periph_irq_pkg::irq_src_t    src_i,
    output periph_bus_pkg::apb_data_t   rdata_o,
    output logic                        offset_err_o,
    output logic                        irq_o
);

    periph_irq_pkg::irq_prio_t prio_q [`PERIPH_NUM_SRC];
    periph_irq_pkg::irq_src_t  enable_q;
    periph_irq_pkg::irq_prio_t threshold_q;
    periph_irq_pkg::irq_src_t  pending_q;
    periph_irq_pkg::irq_src_t  pending_d;
    periph_irq_pkg::irq_src_t  inflight_q;
    periph_irq_pkg::irq_src_t  inflight_d;
    periph_irq_pkg::irq_src_t  above_thr;

    periph_bus_pkg::reg_offset_t prio_off;
    periph_irq_pkg::irq_id_t     prio_id;
    periph_irq_pkg::irq_id_t     best_id;
    periph_irq_pkg::irq_prio_t   best_prio;
    periph_irq_pkg::irq_id_t     complete_id;

    logic prio_hit;
    logic pend_hit;
    logic enable_hit;
    logic thr_hit;
    logic claim_hit;
    logic claim_rd;
    logic claim_wr;

    // --------------------------------------------------
    // Register decode
    // --------------------------------------------------
    assign prio_off   = offset_i - `PLIC_PRIO_BASE;
    assign prio_id    = periph_irq_pkg::irq_id_t'(prio_off >> 2);
    assign prio_hit   = (prio_off < periph_bus_pkg::reg_offset_t'(4 * `PERIPH_NUM_SRC))
                        && (prio_off[1:0] == 2'b00);
    assign pend_hit   = (offset_i == `PLIC_PENDING);
    assign enable_hit = (offset_i == `PLIC_ENABLE);
    assign thr_hit    = (offset_i == `PLIC_THRESHOLD);
    assign claim_hit  = (offset_i == `PLIC_CLAIM);

    assign claim_rd    = re_i & claim_hit;
    assign claim_wr    = we_i & claim_hit;
    assign complete_id = periph_irq_pkg::irq_id_t'(wdata_i);

    // Pending is read-only
    assign offset_err_o = (re_i & ~(prio_hit | pend_hit | enable_hit | thr_hit | claim_hit))
                        | (we_i & ~(prio_hit | enable_hit | thr_hit | claim_hit));

    // Highest enabled pending priority above threshold, lowest id on ties
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 1; i < `PERIPH_NUM_SRC; i++) begin
            above_thr[i] = prio_q[i] > threshold_q;
            if (pending_q[i] && enable_q[i] && prio_q[i] > best_prio) begin
                best_id   = periph_irq_pkg::irq_id_t'(i);
                best_prio = prio_q[i];
            end
        end
        above_thr[0] = 1'b0;
    end

    assign irq_o = |(pending_q & enable_q & above_thr);

    // Gateways plus claim/complete
    always_comb begin
        pending_d  = pending_q | (src_i & ~inflight_q);
        inflight_d = inflight_q;
        if (claim_rd && best_id != '0) begin
            pending_d[best_id]  = 1'b0;
            inflight_d[best_id] = 1'b1;
        end
        if (claim_wr) begin
            inflight_d[complete_id] = 1'b0;
        end
        pending_d[0]  = 1'b0;
        inflight_d[0] = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
            pending_q   <= '0;
            inflight_q  <= '0;
        end else begin
            pending_q  <= pending_d;
            inflight_q <= inflight_d;
            if (we_i && prio_hit) begin
                prio_q[prio_id] <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
            if (we_i && enable_hit) begin
                enable_q <= wdata_i[`PERIPH_NUM_SRC-1:0];
            end
            if (we_i && thr_hit) begin
                threshold_q <= wdata_i[`PERIPH_PRIO_W-1:0];
            end
        end
    end

    // Read path
    always_comb begin
        rdata_o = '0;
        if (prio_hit) begin
            rdata_o = periph_bus_pkg::apb_data_t'(prio_q[prio_id]);
        end else if (pend_hit) begin
            rdata_o = periph_bus_pkg::apb_data_t'(pending_q);
        end else if (enable_hit) begin
            rdata_o = periph_bus_pkg::apb_data_t'(enable_q);
        end else if (thr_hit) begin
            rdata_o = periph_bus_pkg::apb_data_t'(threshold_q);
        end else if (claim_hit) begin
            rdata_o = periph_bus_pkg::apb_data_t'(best_id);
        end
    end

    // A claimed source stays out of pending until completed
    pend_inflight_excl_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (pending_q & inflight_q) == '0
    );

    claim_valid_a: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        irq_o |-> (best_id != '0)
    );

endmodule

//--- periph_resp_mux.sv
// APB response mux
// Read data and error of the addressed slave, error slave for unmapped regions

`timescale 1ns/1ps

`include "periph_defines.svh"

module periph_resp_mux (
    input  periph_bus_pkg::periph_region_e region_i,
    input  periph_bus_pkg::apb_data_t      plic_rdata_i,
    input  logic                           plic_err_i,
    input  periph_bus_pkg::apb_data_t      timer_rdata_i,
    input  logic                           timer_err_i,
    output periph_bus_pkg::apb_data_t      prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);

    always_comb begin
        case (region_i)
            periph_bus_pkg::REGION_PLIC: begin
                prdata_o  = plic_rdata_i;
                pslverr_o = plic_err_i;
            end
            periph_bus_pkg::REGION_TIMER: begin
                prdata_o  = timer_rdata_i;
                pslverr_o = timer_err_i;
            end
            default: begin
                // Unmapped region
                prdata_o  = `PERIPH_ERR_DATA;
                pslverr_o = 1'b1;
            end
        endcase
    end

    // Zero wait states on every slave
    assign pready_o = 1'b1;

endmodule

//--- periph_subsystem.sv
// Peripheral subsystem top
// APB decoder, timer, interrupt controller, response mux, source assembly

`timescale 1ns/1ps

module periph_subsystem (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  periph_bus_pkg::apb_addr_t paddr_i,
    input  periph_bus_pkg::apb_data_t pwdata_i,
    output periph_bus_pkg::apb_data_t prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    input  logic [4:0]                evt_i,
    output logic                      irq_o
);

    periph_bus_pkg::periph_region_e region;
    periph_bus_pkg::reg_offset_t    offset;
    periph_bus_pkg::apb_data_t      plic_rdata;
    periph_bus_pkg::apb_data_t      timer_rdata;
    periph_irq_pkg::irq_src_t       irq_src;

    logic       plic_we;
    logic       plic_re;
    logic       timer_we;
    logic       timer_re;
    logic       plic_err;
    logic       timer_err;
    logic [1:0] timer_irq;

    periph_apb_decoder u_decoder (
        .clk_i      ( clk_i     ),
        .rst_n_i    ( rst_n_i   ),
        .psel_i     ( psel_i    ),
        .penable_i  ( penable_i ),
        .pwrite_i   ( pwrite_i  ),
        .paddr_i    ( paddr_i   ),
        .region_o   ( region    ),
        .offset_o   ( offset    ),
        .plic_we_o  ( plic_we   ),
        .plic_re_o  ( plic_re   ),
        .timer_we_o ( timer_we  ),
        .timer_re_o ( timer_re  )
    );

    periph_timer u_timer (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .we_i         ( timer_we    ),
        .re_i         ( timer_re    ),
        .offset_i     ( offset      ),
        .wdata_i      ( pwdata_i    ),
        .rdata_o      ( timer_rdata ),
        .offset_err_o ( timer_err   ),
        .irq_o        ( timer_irq   )
    );

    // Id 0 reserved, then timers, then external events
    assign irq_src = {evt_i, timer_irq, 1'b0};

    periph_plic u_plic (
        .clk_i        ( clk_i      ),
        .rst_n_i      ( rst_n_i    ),
        .we_i         ( plic_we    ),
        .re_i         ( plic_re    ),
        .offset_i     ( offset     ),
        .wdata_i      ( pwdata_i   ),
        .src_i        ( irq_src    ),
        .rdata_o      ( plic_rdata ),
        .offset_err_o ( plic_err   ),
        .irq_o        ( irq_o      )
    );

    periph_resp_mux u_resp_mux (
        .region_i      ( region      ),
        .plic_rdata_i  ( plic_rdata  ),
        .plic_err_i    ( plic_err    ),
        .timer_rdata_i ( timer_rdata ),
        .timer_err_i   ( timer_err   ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   )
    );

endmodule

//--- tb_periph_subsystem.sv
// Testbench for the peripheral subsystem
// APB tasks, timer and interrupt controller stimulus, checking assertions

`timescale 1ns/1ps

`include "periph_defines.svh"

module tb_periph_subsystem;

    logic                           clk = 1'b0;
    logic                           rst_n;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    periph_bus_pkg::apb_addr_t      paddr;
    periph_bus_pkg::apb_data_t      pwdata;
    periph_bus_pkg::apb_data_t      prdata;
    logic                           pready;
    logic                           pslverr;
    logic [4:0]                     evt;
    logic                           irq;

    integer                         seed;
    int                             cycle_cnt = 0;
    periph_irq_pkg::irq_prio_t      prio_exp [`PERIPH_NUM_SRC];

    periph_subsystem u_periph_subsystem (
        .clk_i     ( clk     ),
        .rst_n_i   ( rst_n   ),
        .psel_i    ( psel    ),
        .penable_i ( penable ),
        .pwrite_i  ( pwrite  ),
        .paddr_i   ( paddr   ),
        .pwdata_i  ( pwdata  ),
        .prdata_o  ( prdata  ),
        .pready_o  ( pready  ),
        .pslverr_o ( pslverr ),
        .evt_i     ( evt     ),
        .irq_o     ( irq     )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------------------------------------
    // Failure reporting and address helpers
    // --------------------------------------------------
    task automatic report_mismatch(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after 2000 cycles waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    function automatic periph_bus_pkg::apb_addr_t plic_addr(input logic [11:0] off);
        return {16'h0000, `PERIPH_REGION_PLIC, off};
    endfunction

    // Timer 0 only
    function automatic periph_bus_pkg::apb_addr_t timer_addr(input logic [3:0] off);
        return {16'h0000, `PERIPH_REGION_TIMER, 8'h00, off};
    endfunction

    // Zero wait state bus
    pready_high_a: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else report_mismatch("pready_o is low");

    irq_known_a: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(irq))
        else report_mismatch("irq_o is unknown");

    // --------------------------------------------------
    // APB transfers
    // --------------------------------------------------
    task automatic apb_write(input periph_bus_pkg::apb_addr_t addr,
                             input periph_bus_pkg::apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        err = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input periph_bus_pkg::apb_addr_t addr,
                            output periph_bus_pkg::apb_data_t data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_expect(input periph_bus_pkg::apb_addr_t addr,
                               input periph_bus_pkg::apb_data_t exp_data,
                               input logic exp_err, input string what);
        periph_bus_pkg::apb_data_t data;
        logic err;
        apb_read(addr, data, err);
        assert (data === exp_data && err === exp_err)
            else report_mismatch($sformatf("%s read %h err %b, expected %h err %b",
                                           what, data, err, exp_data, exp_err));
    endtask

    task automatic write_expect(input periph_bus_pkg::apb_addr_t addr,
                                input periph_bus_pkg::apb_data_t data,
                                input logic exp_err, input string what);
        logic err;
        apb_write(addr, data, err);
        assert (err === exp_err)
            else report_mismatch($sformatf("%s write err %b, expected %b", what, err, exp_err));
    endtask

    // --------------------------------------------------
    // Polling waits
    // --------------------------------------------------
    task automatic wait_irq_level(input logic level, input string what);
        int start;
        start = cycle_cnt;
        while (irq !== level) begin
            if (cycle_cnt - start >= 2000) report_timeout(what);
            @(negedge clk);
        end
    endtask

    task automatic wait_timer_pending();
        periph_bus_pkg::apb_data_t data;
        logic err;
        int start;
        start = cycle_cnt;
        apb_read(timer_addr(`TIMER_STATUS), data, err);
        while (data[0] !== 1'b1) begin
            if (cycle_cnt - start >= 2000) report_timeout("timer 0 status pending");
            apb_read(timer_addr(`TIMER_STATUS), data, err);
        end
    endtask

    initial begin
        logic [31:0]               rnd;
        logic [2:0]                id3;
        logic [2:0]                best_id;
        periph_irq_pkg::irq_prio_t best_p;
        logic [7:0]                pend_exp;

        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        evt     = '0;
        rst_n   = 1'b0;
        seed    = 40081;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset state
        assert (irq === 1'b0) else report_mismatch("irq_o high after reset");
        read_expect(plic_addr(`PLIC_ENABLE), 32'h0, 1'b0, "enable");
        read_expect(plic_addr(`PLIC_THRESHOLD), 32'h0, 1'b0, "threshold");
        read_expect(plic_addr(`PLIC_PENDING), 32'h0, 1'b0, "pending");
        read_expect(plic_addr(`PLIC_CLAIM), 32'h0, 1'b0, "claim");

        // Error slave and read-only pending
        read_expect({16'h0000, 4'h5, 12'h000}, `PERIPH_ERR_DATA, 1'b1, "region 5");
        write_expect({16'h0000, 4'h5, 12'h000}, 32'h1234_5678, 1'b1, "region 5");
        write_expect(plic_addr(`PLIC_PENDING), 32'h0000_00FF, 1'b1, "pending");

        // Priority registers keep only the low bits
        for (int i = 0; i < `PERIPH_NUM_SRC; i++) begin
            rnd = $random(seed);
            id3 = 3'(i);
            write_expect(plic_addr({7'b0, id3, 2'b00}), rnd, 1'b0, "priority");
            read_expect(plic_addr({7'b0, id3, 2'b00}), {29'b0, rnd[2:0]}, 1'b0, "priority");
        end

        // --------------------------------------------------
        // Timer 0 into source 1
        // --------------------------------------------------
        write_expect(plic_addr({7'b0, 3'd1, 2'b00}), 32'd1, 1'b0, "priority 1");
        write_expect(plic_addr(`PLIC_THRESHOLD), 32'd0, 1'b0, "threshold");
        write_expect(plic_addr(`PLIC_ENABLE), 32'h0000_0002, 1'b0, "enable");
        write_expect(timer_addr(`TIMER_COMPARE), 32'd20, 1'b0, "timer compare");
        write_expect(timer_addr(`TIMER_CTRL), 32'd1, 1'b0, "timer ctrl");
        wait_timer_pending();
        wait_irq_level(1'b1, "irq_o from timer 0");
        write_expect(timer_addr(`TIMER_CTRL), 32'd0, 1'b0, "timer ctrl");
        write_expect(timer_addr(`TIMER_STATUS), 32'd1, 1'b0, "timer status");
        read_expect(timer_addr(`TIMER_STATUS), 32'd0, 1'b0, "timer status");

        // --------------------------------------------------
        // External events and claim
        // --------------------------------------------------
        best_id = 3'd0;
        best_p  = '0;
        write_expect(plic_addr(`PLIC_ENABLE), 32'h0000_00F8, 1'b0, "enable");
        for (int i = 3; i < `PERIPH_NUM_SRC; i++) begin
            rnd = $random(seed);
            id3 = 3'(i);
            prio_exp[i] = (rnd[2:0] == 3'd0) ? 3'd7 : rnd[2:0];
            write_expect(plic_addr({7'b0, id3, 2'b00}), {29'b0, prio_exp[i]}, 1'b0, "priority");
            // Strict compare keeps the lowest id on ties
            if (prio_exp[i] > best_p) begin
                best_p  = prio_exp[i];
                best_id = id3;
            end
        end
        @(negedge clk);
        evt = 5'h1F;
        wait_irq_level(1'b1, "irq_o from external events");
        read_expect(plic_addr(`PLIC_CLAIM), {29'b0, best_id}, 1'b0, "claim");
        // Four enabled sources with nonzero priority are still pending
        assert (irq === 1'b1) else report_mismatch("irq_o low with sources still pending");
        write_expect(plic_addr(`PLIC_THRESHOLD), {29'b0, best_p}, 1'b0, "threshold");
        assert (irq === 1'b0) else report_mismatch("irq_o high with threshold at top priority");

        // Claimed source stays out of pending until complete
        pend_exp          = 8'hFA;
        pend_exp[best_id] = 1'b0;
        read_expect(plic_addr(`PLIC_PENDING), {24'b0, pend_exp}, 1'b0, "pending in flight");
        read_expect(plic_addr(`PLIC_PENDING), {24'b0, pend_exp}, 1'b0, "pending in flight");
        write_expect(plic_addr(`PLIC_CLAIM), {29'b0, best_id}, 1'b0, "complete");
        read_expect(plic_addr(`PLIC_PENDING), 32'h0000_00FA, 1'b0, "pending after complete");

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb.f
+incdir+.
periph_bus_pkg.sv
periph_irq_pkg.sv
periph_apb_decoder.sv
periph_timer.sv
periph_plic.sv
periph_resp_mux.sv
periph_subsystem.sv
tb_periph_subsystem.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log for PASS"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_periph_subsystem
	-./obj_dir/Vtb_periph_subsystem > sim.log 2>&1
	@cat sim.log
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
